/* decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// lanes decoded per cycle.
`define DECODER_WIDTH 2
// one dequeue strobe per decode lane.
`define ISSUE_WIDTH `DECODER_WIDTH

// entries held by each issue queue.
`define IQ_DEPTH 8

// fetches below this address are outside the boot window.
`define BOOT_BASE 32'h1c00_0000
// filler word pushed into lanes fetched outside the boot window.
`define ERTN_INST 32'h4c00_0020

`define EXC_SLOTS 6
`define EXC_SLOT_ID 1 // slot written by decode.

`endif

/* la_isa_pkg.sv */
`default_nettype none

package la_isa;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLLI,
        OP_ADDI,
        OP_LU12I,
        OP_PCADDU12I,
        OP_LD_W,
        OP_ST_W,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_B,
        OP_BL,
        OP_JIRL,
        OP_ERTN,
        OP_SYSCALL,
        OP_BREAK,
        OP_INVALID
    } op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_COND,
        BR_DIRECT,
        BR_CALL, // bl links into r1.
        BR_INDIRECT
    } br_kind_t;

    // ecode values of the architecture.
    localparam logic [6:0] EXC_SYS = 7'h0b;
    localparam logic [6:0] EXC_BRK = 7'h0c;
    localparam logic [6:0] EXC_INE = 7'h0d;

    // fixed words.
    localparam logic [31:0] INST_NOP = 32'h0340_0000; // andi r0, r0, 0.
    localparam logic [31:0] INST_ERTN = 32'h0648_3800;

    // major opcode fields in inst[31:15].
    localparam logic [16:0] OPC17_ADD_W = 17'h00020;
    localparam logic [16:0] OPC17_SUB_W = 17'h00022;
    localparam logic [16:0] OPC17_AND = 17'h00029;
    localparam logic [16:0] OPC17_OR = 17'h0002a;
    localparam logic [16:0] OPC17_XOR = 17'h0002b;
    localparam logic [16:0] OPC17_BREAK = 17'h00054;
    localparam logic [16:0] OPC17_SYSCALL = 17'h00056;
    localparam logic [16:0] OPC17_SLLI_W = 17'h00081;

    // inst[31:22].
    localparam logic [9:0] OPC10_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC10_LD_W = 10'h0a2;
    localparam logic [9:0] OPC10_ST_W = 10'h0a6;

    // inst[31:25].
    localparam logic [6:0] OPC7_LU12I_W = 7'h0a;
    localparam logic [6:0] OPC7_PCADDU12I = 7'h0e;

    // inst[31:26].
    localparam logic [5:0] OPC6_JIRL = 6'h13;
    localparam logic [5:0] OPC6_B = 6'h14;
    localparam logic [5:0] OPC6_BL = 6'h15;
    localparam logic [5:0] OPC6_BEQ = 6'h16;
    localparam logic [5:0] OPC6_BNE = 6'h17;
    localparam logic [5:0] OPC6_BLT = 6'h18;

endpackage

`default_nettype wire

/* pipeline_types_pkg.sv */
`default_nettype none

`include "decode_params.svh"

package pipeline_types;

    typedef logic [31:0] bus32_t;

    // one fetched lane, as the front end holds it.
    typedef struct packed {
        bus32_t pc;
        bus32_t inst;
        logic pre_is_branch;
        logic pre_is_branch_taken;
        bus32_t pre_branch_addr;
        logic [`EXC_SLOTS-1:0] is_exception;
        logic [`EXC_SLOTS-1:0][6:0] exception_cause;
    } front_lane_t;

    // decoded record handed to dispatch.
    typedef struct packed {
        logic valid;
        bus32_t pc;
        la_isa::op_t op;
        la_isa::br_kind_t br_kind;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        bus32_t imm;
        logic reg_we;
        logic pre_is_branch;
        logic pre_is_branch_taken;
        bus32_t pre_branch_addr;
        logic [`EXC_SLOTS-1:0] is_exception;
        logic [`EXC_SLOTS-1:0][6:0] exception_cause;
    } id_dispatch_t;

endpackage

`default_nettype wire

/* instr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module instr_decode (
    input  pipeline_types::front_lane_t  lane,
    output pipeline_types::id_dispatch_t id_o
);

    pipeline_types::bus32_t inst;
    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;
    logic [31:0] imm_si12;
    logic [31:0] imm_ui5;
    logic [31:0] imm_si20;
    logic [31:0] imm_offs16;
    logic [31:0] imm_offs26;
    la_isa::op_t op;
    logic raise_exc;
    logic [6:0] exc_code;

    assign inst = lane.inst;
    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui5 = {27'b0, inst[14:10]};
    assign imm_si20 = {inst[24:5], 12'b0};
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}; // high part sits low.

    // exact words are matched before opcode fields.
    always_comb begin
        op = la_isa::OP_INVALID;
        if (inst == `ERTN_INST || inst == la_isa::INST_ERTN) begin
            op = la_isa::OP_ERTN; // boot filler decodes as ertn too.
        end else if (inst == la_isa::INST_NOP) begin
            op = la_isa::OP_NOP;
        end else if (inst[31:15] == la_isa::OPC17_ADD_W) begin
            op = la_isa::OP_ADD;
        end else if (inst[31:15] == la_isa::OPC17_SUB_W) begin
            op = la_isa::OP_SUB;
        end else if (inst[31:15] == la_isa::OPC17_AND) begin
            op = la_isa::OP_AND;
        end else if (inst[31:15] == la_isa::OPC17_OR) begin
            op = la_isa::OP_OR;
        end else if (inst[31:15] == la_isa::OPC17_XOR) begin
            op = la_isa::OP_XOR;
        end else if (inst[31:15] == la_isa::OPC17_SLLI_W) begin
            op = la_isa::OP_SLLI;
        end else if (inst[31:15] == la_isa::OPC17_SYSCALL) begin
            op = la_isa::OP_SYSCALL;
        end else if (inst[31:15] == la_isa::OPC17_BREAK) begin
            op = la_isa::OP_BREAK;
        end else if (inst[31:22] == la_isa::OPC10_ADDI_W) begin
            op = la_isa::OP_ADDI;
        end else if (inst[31:22] == la_isa::OPC10_LD_W) begin
            op = la_isa::OP_LD_W;
        end else if (inst[31:22] == la_isa::OPC10_ST_W) begin
            op = la_isa::OP_ST_W;
        end else if (inst[31:25] == la_isa::OPC7_LU12I_W) begin
            op = la_isa::OP_LU12I;
        end else if (inst[31:25] == la_isa::OPC7_PCADDU12I) begin
            op = la_isa::OP_PCADDU12I;
        end else begin
            case (inst[31:26])
                la_isa::OPC6_JIRL: op = la_isa::OP_JIRL;
                la_isa::OPC6_B:    op = la_isa::OP_B;
                la_isa::OPC6_BL:   op = la_isa::OP_BL;
                la_isa::OPC6_BEQ:  op = la_isa::OP_BEQ;
                la_isa::OPC6_BNE:  op = la_isa::OP_BNE;
                la_isa::OPC6_BLT:  op = la_isa::OP_BLT;
                default:           op = la_isa::OP_INVALID;
            endcase
        end
    end

    always_comb begin
        raise_exc = 1'b1;
        case (op)
            la_isa::OP_INVALID: exc_code = la_isa::EXC_INE;
            la_isa::OP_SYSCALL: exc_code = la_isa::EXC_SYS;
            la_isa::OP_BREAK:   exc_code = la_isa::EXC_BRK;
            default: begin
                raise_exc = 1'b0;
                exc_code = 7'd0;
            end
        endcase
    end

    always_comb begin
        id_o = '0; // valid is set by the stage.
        id_o.pc = lane.pc;
        id_o.op = op;
        id_o.br_kind = la_isa::BR_NONE;
        id_o.rd = rd;
        id_o.rj = rj;
        id_o.rk = rk;
        id_o.pre_is_branch = lane.pre_is_branch;
        id_o.pre_is_branch_taken = lane.pre_is_branch_taken;
        id_o.pre_branch_addr = lane.pre_branch_addr;
        id_o.is_exception = lane.is_exception;
        id_o.exception_cause = lane.exception_cause;
        case (op)
            la_isa::OP_ADD, la_isa::OP_SUB, la_isa::OP_AND,
            la_isa::OP_OR, la_isa::OP_XOR: begin
                id_o.reg_we = 1'b1;
            end
            la_isa::OP_SLLI: begin
                id_o.imm = imm_ui5;
                id_o.reg_we = 1'b1;
            end
            la_isa::OP_ADDI, la_isa::OP_LD_W: begin
                id_o.imm = imm_si12;
                id_o.reg_we = 1'b1;
            end
            la_isa::OP_ST_W: id_o.imm = imm_si12; // rd is store data.
            la_isa::OP_LU12I, la_isa::OP_PCADDU12I: begin
                id_o.imm = imm_si20;
                id_o.reg_we = 1'b1;
            end
            la_isa::OP_BEQ, la_isa::OP_BNE, la_isa::OP_BLT: begin
                id_o.imm = imm_offs16;
                id_o.br_kind = la_isa::BR_COND;
            end
            la_isa::OP_B: begin
                id_o.imm = imm_offs26;
                id_o.br_kind = la_isa::BR_DIRECT;
            end
            la_isa::OP_BL: begin
                id_o.imm = imm_offs26;
                id_o.br_kind = la_isa::BR_CALL;
                id_o.rd = 5'd1; // link register.
                id_o.reg_we = 1'b1;
            end
            la_isa::OP_JIRL: begin
                id_o.imm = imm_offs16;
                id_o.br_kind = la_isa::BR_INDIRECT;
                id_o.reg_we = 1'b1;
            end
            default: ;
        endcase
        if (id_o.rd == 5'd0) id_o.reg_we = 1'b0; // r0 is hardwired.
        // an earlier fetch exception wins.
        if (raise_exc && !(|lane.is_exception[`EXC_SLOT_ID-1:0])) begin
            id_o.is_exception[`EXC_SLOT_ID] = 1'b1;
            id_o.exception_cause[`EXC_SLOT_ID] = exc_code;
        end
    end

endmodule

`default_nettype wire

/* issue_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  enqueue_en,
    input  logic [DATA_WIDTH-1:0] enqueue_data,
    input  logic                  dequeue_en,
    output logic [DATA_WIDTH-1:0] dequeue_data,
    output logic                  empty,
    output logic                  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign do_wr = enqueue_en && !full;
    assign do_rd = dequeue_en && !empty; // strobe on empty is dropped.

    assign dequeue_data = mem[rd_ptr]; // head is read without a register.

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= enqueue_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module decode_stage (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              flush,
    input  logic                                              pause,
    input  pipeline_types::front_lane_t [`DECODER_WIDTH-1:0]  lanes,
    input  logic [`ISSUE_WIDTH-1:0]                           dequeue_en,
    output logic                                              pause_decoder,
    output pipeline_types::id_dispatch_t [`DECODER_WIDTH-1:0] dispatch
);

    logic [`DECODER_WIDTH-1:0] full;
    logic [`DECODER_WIDTH-1:0] empty;

    for (genvar i = 0; i < `DECODER_WIDTH; i++) begin : g_lane
        pipeline_types::front_lane_t lane_in;
        pipeline_types::id_dispatch_t id_rec;
        pipeline_types::id_dispatch_t enq_rec;
        pipeline_types::id_dispatch_t head_rec;
        pipeline_types::id_dispatch_t disp_rec;
        logic enqueue_en;

        // outside the boot window the word is replaced.
        always_comb begin
            lane_in = lanes[i];
            if (lanes[i].pc != 32'd0 && lanes[i].pc < `BOOT_BASE) begin
                lane_in.inst = `ERTN_INST;
            end
        end

        instr_decode u_instr_decode (
            .lane (lane_in),
            .id_o (id_rec)
        );

        always_comb begin
            enq_rec = id_rec;
            enq_rec.valid = 1'b1;
        end

        // pc zero marks an empty slot.
        assign enqueue_en = (lanes[i].pc != 32'd0) && !pause && !full[i] && !flush;

        issue_fifo #(
            .DATA_WIDTH ($bits(pipeline_types::id_dispatch_t)),
            .DEPTH      (`IQ_DEPTH)
        ) u_issue_fifo (
            .clk          (clk),
            .rst_n        (rst_n),
            .flush        (flush),
            .enqueue_en   (enqueue_en),
            .enqueue_data (enq_rec),
            .dequeue_en   (dequeue_en[i]),
            .dequeue_data (head_rec),
            .empty        (empty[i]),
            .full         (full[i])
        );

        always_comb begin
            disp_rec = head_rec;
            disp_rec.valid = !empty[i]; // stale ram data is masked here.
        end

        assign dispatch[i] = disp_rec;
    end

    assign pause_decoder = |full; // controller answers with pause.

endmodule

`default_nettype wire

/* tb_decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module tb_decode_stage;

    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [6:0] FETCH_CAUSE = 7'h08; // adef style fetch fault.

    logic clk = 1'b0;
    logic rst_n;
    logic flush;
    logic pause;
    pipeline_types::front_lane_t [`DECODER_WIDTH-1:0] lanes;
    logic [`ISSUE_WIDTH-1:0] dequeue_en;
    logic pause_decoder;
    pipeline_types::id_dispatch_t [`DECODER_WIDTH-1:0] dispatch;

    // copies of what sits on the DUT inputs.
    pipeline_types::front_lane_t [`DECODER_WIDTH-1:0] drv_lanes;
    logic [`ISSUE_WIDTH-1:0] drv_deq;
    logic drv_flush;
    logic drv_pause;
    pipeline_types::id_dispatch_t pend_rec [`DECODER_WIDTH];
    logic [`DECODER_WIDTH-1:0] pend_v;
    pipeline_types::id_dispatch_t exp_q [`DECODER_WIDTH][$]; // expected queue contents.

    logic [31:0] rng_state = 32'h5c66;
    int pause_left = 0;
    logic stall = 1'b0;
    logic timed_out = 1'b0;
    int value_errors = 0;
    int other_errors = 0;
    int checks = 0;

    decode_stage decode_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .pause         (pause),
        .lanes         (lanes),
        .dequeue_en    (dequeue_en),
        .pause_decoder (pause_decoder),
        .dispatch      (dispatch)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void check_field(input int ln, input string name,
                                        input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("ERROR %0d ns: lane %0d field %s is %0h, expected %0h",
                     $time, ln, name, got, exp);
        end
    endfunction

    function automatic void compare_record(input int ln, input pipeline_types::id_dispatch_t got,
                                           input pipeline_types::id_dispatch_t exp);
        check_field(ln, "pc", 64'(got.pc), 64'(exp.pc));
        check_field(ln, "op", 64'(got.op), 64'(exp.op));
        check_field(ln, "br_kind", 64'(got.br_kind), 64'(exp.br_kind));
        check_field(ln, "rd", 64'(got.rd), 64'(exp.rd));
        check_field(ln, "rj", 64'(got.rj), 64'(exp.rj));
        check_field(ln, "rk", 64'(got.rk), 64'(exp.rk));
        check_field(ln, "imm", 64'(got.imm), 64'(exp.imm));
        check_field(ln, "reg_we", 64'(got.reg_we), 64'(exp.reg_we));
        check_field(ln, "pre_is_branch", 64'(got.pre_is_branch), 64'(exp.pre_is_branch));
        check_field(ln, "pre_taken", 64'(got.pre_is_branch_taken),
                    64'(exp.pre_is_branch_taken));
        check_field(ln, "pre_branch_addr", 64'(got.pre_branch_addr), 64'(exp.pre_branch_addr));
        check_field(ln, "is_exception", 64'(got.is_exception), 64'(exp.is_exception));
        check_field(ln, "exception_cause", 64'(got.exception_cause), 64'(exp.exception_cause));
    endfunction

    function automatic logic any_queue_full();
        logic f;
        f = 1'b0;
        for (int i = 0; i < `DECODER_WIDTH; i++) begin
            f = f | (exp_q[i].size() == `IQ_DEPTH);
        end
        return f;
    endfunction

    // drives one clock, samples before the edge updates, then updates the model.
    task automatic step();
        logic [`DECODER_WIDTH-1:0] accept;
        lanes <= drv_lanes;
        dequeue_en <= drv_deq;
        flush <= drv_flush;
        pause <= drv_pause;
        @(posedge clk);
        assert (pause_decoder === any_queue_full()) else begin
            value_errors++;
            $display("ERROR %0d ns: pause_decoder is %0b, expected %0b",
                     $time, pause_decoder, any_queue_full());
        end
        for (int i = 0; i < `DECODER_WIDTH; i++) begin
            assert (dispatch[i].valid === (exp_q[i].size() != 0)) else begin
                value_errors++;
                $display("ERROR %0d ns: lane %0d dispatch valid is %0b with %0d queued",
                         $time, i, dispatch[i].valid, exp_q[i].size());
            end
            accept[i] = (drv_lanes[i].pc != 32'd0) && !drv_pause && !drv_flush
                        && (exp_q[i].size() < `IQ_DEPTH);
            if (drv_deq[i] && dispatch[i].valid && exp_q[i].size() != 0) begin
                checks++;
                compare_record(i, dispatch[i], exp_q[i][0]);
            end
            if (drv_flush) begin
                exp_q[i].delete();
            end else begin
                if (drv_deq[i] && exp_q[i].size() != 0) void'(exp_q[i].pop_front());
                if (accept[i]) exp_q[i].push_back(pend_rec[i]);
            end
            if (accept[i]) drv_lanes[i] = '0;
        end
        rng_state = xorshift32(rng_state);
        drv_deq = stall ? '0 : `ISSUE_WIDTH'(rng_state >> 4);
        if (pause_left > 0) pause_left--;
        drv_pause = (pause_left > 0) || any_queue_full(); // controller answer.
    endtask

    task automatic present_pending();
        int n;
        logic busy;
        n = 0;
        do begin
            step();
            n++;
            busy = 1'b0;
            for (int i = 0; i < `DECODER_WIDTH; i++) busy = busy | (drv_lanes[i].pc != 32'd0);
        end while (busy && n < TIMEOUT_CYCLES);
        if (busy) begin
            timed_out = 1'b1;
            $display("timeout: a lane was not accepted within %0d cycles", TIMEOUT_CYCLES);
        end
        pend_v = '0;
    endtask

    task automatic drain_queues();
        int n;
        logic left;
        stall = 1'b0;
        n = 0;
        left = 1'b1;
        while (left && n < TIMEOUT_CYCLES) begin
            step();
            n++;
            left = 1'b0;
            for (int i = 0; i < `DECODER_WIDTH; i++) left = left | (exp_q[i].size() != 0);
        end
        if (left) begin
            timed_out = 1'b1;
            $display("timeout: the issue queues did not drain within %0d cycles",
                     TIMEOUT_CYCLES);
        end
    endtask

    function automatic void load_lane(input int ln, input logic [31:0] pc,
                                      input logic [31:0] inst, input int fexc,
                                      input la_isa::op_t op, input la_isa::br_kind_t br,
                                      input int rd, input int rj, input int rk,
                                      input logic [31:0] imm, input int we);
        pipeline_types::front_lane_t l;
        pipeline_types::id_dispatch_t e;
        l = '0;
        l.pc = pc;
        l.inst = inst;
        l.pre_is_branch = pc[2];
        l.pre_is_branch_taken = pc[3];
        l.pre_branch_addr = pc + 32'd8;
        if (fexc != 0) begin
            l.is_exception[0] = 1'b1;
            l.exception_cause[0] = FETCH_CAUSE;
        end
        e = '0;
        e.valid = 1'b1;
        e.pc = pc;
        e.op = op;
        e.br_kind = br;
        e.rd = 5'(rd);
        e.rj = 5'(rj);
        e.rk = 5'(rk);
        e.imm = imm;
        e.reg_we = (we != 0);
        e.pre_is_branch = l.pre_is_branch;
        e.pre_is_branch_taken = l.pre_is_branch_taken;
        e.pre_branch_addr = l.pre_branch_addr;
        e.is_exception = l.is_exception;
        e.exception_cause = l.exception_cause;
        // decode fills its own slot unless fetch already faulted.
        if (fexc == 0 && (op == la_isa::OP_INVALID || op == la_isa::OP_SYSCALL
                          || op == la_isa::OP_BREAK)) begin
            e.is_exception[`EXC_SLOT_ID] = 1'b1;
            e.exception_cause[`EXC_SLOT_ID] = (op == la_isa::OP_INVALID) ? la_isa::EXC_INE :
                (op == la_isa::OP_SYSCALL) ? la_isa::EXC_SYS : la_isa::EXC_BRK;
        end
        drv_lanes[ln] = l;
        pend_rec[ln] = e;
        pend_v[ln] = 1'b1;
    endfunction

    function automatic la_isa::op_t op_from_name(input string s);
        la_isa::op_t o;
        o = o.first();
        for (int k = 0; k < o.num(); k++) begin
            if (o.name() == s) return o;
            o = o.next();
        end
        other_errors++;
        $display("unknown opcode name %s in the vector file", s);
        return la_isa::OP_INVALID;
    endfunction

    function automatic la_isa::br_kind_t br_from_name(input string s);
        la_isa::br_kind_t b;
        b = b.first();
        for (int k = 0; k < b.num(); k++) begin
            if (b.name() == s) return b;
            b = b.next();
        end
        other_errors++;
        $display("unknown branch class %s in the vector file", s);
        return la_isa::BR_NONE;
    endfunction

    initial begin
        int fd;
        int cnt;
        int ln;
        int fexc;
        int rd;
        int rj;
        int rk;
        int we;
        int cycles;
        string line;
        string tok;
        string op_s;
        string br_s;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] imm;
        drv_lanes = '0;
        drv_deq = '0;
        drv_flush = 1'b0;
        drv_pause = 1'b0;
        pend_v = '0;
        rst_n <= 1'b0;
        lanes <= '0;
        dequeue_en <= '0;
        flush <= 1'b0;
        pause <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("decode_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open decode_vectors.txt");
        end
        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            cnt = $sscanf(line, "%s", tok);
            if (cnt < 1 || tok.substr(0, 0) == "#") continue;
            if (tok == "L") begin
                cnt = $sscanf(line, "%s %d %h %h %d %s %s %d %d %d %h %d", tok, ln, pc, inst,
                              fexc, op_s, br_s, rd, rj, rk, imm, we);
                if (cnt != 12 || ln < 0 || ln >= `DECODER_WIDTH) begin
                    other_errors++;
                    $display("malformed lane entry in the vector file: %s", line);
                end else begin
                    if (pend_v[ln]) present_pending();
                    load_lane(ln, pc, inst, fexc, op_from_name(op_s), br_from_name(br_s),
                              rd, rj, rk, imm, we);
                end
            end else begin
                if (pend_v != '0) present_pending();
                if (tok == "FLUSH") begin
                    drv_flush = 1'b1;
                    step();
                    drv_flush = 1'b0;
                end else if (tok == "PAUSE") begin
                    cnt = $sscanf(line, "%s %d", tok, cycles);
                    pause_left = cycles;
                    drv_pause = 1'b1;
                end else if (tok == "STALL_DISPATCH") begin
                    stall = 1'b1;
                end else if (tok == "DRAIN") begin
                    drain_queues();
                end else begin
                    other_errors++;
                    $display("unknown directive %s in the vector file", tok);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (!timed_out && pend_v != '0) present_pending();
        if (!timed_out) drain_queues();
        $display("checks %0d, value errors %0d, other errors %0d, timeouts %0d",
                 checks, value_errors, other_errors, timed_out ? 1 : 0);
        if (value_errors == 0 && other_errors == 0 && !timed_out && checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* decode_vectors.txt */
# L lane pc inst fetch_exc op br_kind rd rj rk imm reg_we   (pc inst imm in hex)
# directives: FLUSH, PAUSE cycles, STALL_DISPATCH, DRAIN
L 0 1c000000 001018a4 0 OP_ADD BR_NONE 4 5 6 00000000 1
L 1 1c000004 00110820 0 OP_SUB BR_NONE 0 1 2 00000000 0
L 0 1c000008 0014a507 0 OP_AND BR_NONE 7 8 9 00000000 1
L 1 1c00000c 0015316a 0 OP_OR BR_NONE 10 11 12 00000000 1
L 0 1c000010 00158c63 0 OP_XOR BR_NONE 3 3 3 00000000 1
L 1 1c000014 00409462 0 OP_SLLI BR_NONE 2 3 5 00000005 1
L 0 1c000018 02bffca4 0 OP_ADDI BR_NONE 4 5 31 ffffffff 1
L 1 1c00001c 288020e6 0 OP_LD_W BR_NONE 6 7 8 00000008 1
L 0 1c000020 29bff0e6 0 OP_ST_W BR_NONE 6 7 28 fffffffc 0
L 1 1c000024 142468a5 0 OP_LU12I BR_NONE 5 5 26 12345000 1
L 0 1c000028 1c000021 0 OP_PCADDU12I BR_NONE 1 1 0 00001000 1
L 1 1c00002c 58001085 0 OP_BEQ BR_COND 5 4 4 00000010 0
L 0 1c000030 5ffff822 0 OP_BNE BR_COND 2 1 30 fffffff8 0
L 1 1c000034 60000464 0 OP_BLT BR_COND 4 3 1 00000004 0
L 0 1c000038 50004000 0 OP_B BR_DIRECT 0 0 16 00000040 0
L 1 1c00003c 57ffffff 0 OP_BL BR_CALL 1 31 31 fffffffc 1
L 0 1c000040 4c0008a1 0 OP_JIRL BR_INDIRECT 1 5 2 00000008 1
L 1 1c000044 03400000 0 OP_NOP BR_NONE 0 0 0 00000000 0
L 0 1c000048 06483800 0 OP_ERTN BR_NONE 0 0 14 00000000 0
L 1 1c00004c 002b0011 0 OP_SYSCALL BR_NONE 17 0 0 00000000 0
L 0 1c000050 002a0000 0 OP_BREAK BR_NONE 0 0 0 00000000 0
L 1 1c000054 ffffffff 0 OP_INVALID BR_NONE 31 31 31 00000000 0
PAUSE 3
L 0 1c000058 ffffffff 1 OP_INVALID BR_NONE 31 31 31 00000000 0
L 1 1c00005c 001018a4 1 OP_ADD BR_NONE 4 5 6 00000000 1
L 0 00001000 001018a4 0 OP_ERTN BR_NONE 0 1 0 00000000 0
L 1 00000000 001018a4 0 OP_ADD BR_NONE 4 5 6 00000000 1
DRAIN
STALL_DISPATCH
L 0 1c000100 001018a4 0 OP_ADD BR_NONE 4 5 6 00000000 1
L 0 1c000104 00110820 0 OP_SUB BR_NONE 0 1 2 00000000 0
L 0 1c000108 0014a507 0 OP_AND BR_NONE 7 8 9 00000000 1
L 0 1c00010c 0015316a 0 OP_OR BR_NONE 10 11 12 00000000 1
L 0 1c000110 00158c63 0 OP_XOR BR_NONE 3 3 3 00000000 1
L 0 1c000114 00409462 0 OP_SLLI BR_NONE 2 3 5 00000005 1
L 0 1c000118 02bffca4 0 OP_ADDI BR_NONE 4 5 31 ffffffff 1
L 0 1c00011c 288020e6 0 OP_LD_W BR_NONE 6 7 8 00000008 1
DRAIN
STALL_DISPATCH
L 0 1c000200 57ffffff 0 OP_BL BR_CALL 1 31 31 fffffffc 1
L 1 1c000204 58001085 0 OP_BEQ BR_COND 5 4 4 00000010 0
FLUSH
DRAIN
L 0 1c000300 4c0008a1 0 OP_JIRL BR_INDIRECT 1 5 2 00000008 1
L 1 1c000304 142468a5 0 OP_LU12I BR_NONE 5 5 26 12345000 1

/* filelist.f */
+incdir+.
la_isa_pkg.sv
pipeline_types_pkg.sv
instr_decode.sv
issue_fifo.sv
decode_stage.sv
tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_decode_stage -f filelist.f
out=$(./obj_dir/Vtb_decode_stage)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
